// ==== all.f ====
+incdir+src
+incdir+test
src/irq_cfg_pkg.sv
src/irq_disp_pkg.sv
src/irq_capture.sv
src/priority_encoder.sv
src/irq_dispatch.sv
src/irq_ctrl_top.sv
test/irq_ctrl_tb.sv

// ==== Makefile ====
# Verilator flow for the interrupt controller
# the simulation exit status carries pass or fail

TB_TOP  := irq_ctrl_tb
RTL_TOP := irq_ctrl_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing -j 0 -f all.f --top-module $(TB_TOP) \
		--Mdir obj_dir -o irq_sim
	./obj_dir/irq_sim

clean:
	rm -rf obj_dir

// ==== test/irq_input.dat ====
# columns: kind arg0 arg1, numbers in hex, unused arguments are 0
# cfg op line (op 0 mask 1 unmask 2 edge 3 level), lines value, wait n, vec line, quiet n
# all lines masked after reset, rises on 4 and 5 stay pending
lines 0030 0
quiet 8 0
lines 0000 0
quiet 4 0
# three edge lines at once come out lowest index first
cfg 1 1
cfg 1 3
cfg 1 9
lines 020a 0
vec 1 0
vec 3 0
vec 9 0
lines 0000 0
quiet 6 0
# line 5 was latched while masked
cfg 1 5
vec 5 0
quiet 4 0
# level line still high at retire is shown again
cfg 3 7
cfg 1 7
lines 0080 0
vec 7 0
lines 0000 0
vec 7 0
quiet 8 0
# line 2 rises while line 8 waits for its ack
cfg 1 8
cfg 1 2
lines 0100 0
wait 3 0
lines 0104 0
vec 8 0
vec 2 0
lines 0000 0
quiet 6 0

// ==== test/irq_ctrl_checks.svh ====
// typed compare tasks for the interrupt controller testbench
// a mismatch prints an error line and ends the run

`ifndef IRQ_CTRL_CHECKS_SVH
`define IRQ_CTRL_CHECKS_SVH

// compare a presented line index
task automatic check_vector(
    input irq_index_t actual,
    input irq_index_t expected,
    input string      what
);
    if (actual !== expected) begin
        $display("** Error @ %0t: %s: got line %0d, expected line %0d",
                 $time, what, actual, expected);
        abort_run("irq_vector differs from the expected line");
    end
endtask

// compare a single control bit
task automatic check_valid(
    input logic  actual,
    input logic  expected,
    input string what
);
    if (actual !== expected) begin
        $display("** Error @ %0t: %s: got %b, expected %b",
                 $time, what, actual, expected);
        abort_run("control bit differs from the expected value");
    end
endtask

`endif

// ==== test/irq_ctrl_tb.sv ====
// testbench for the interrupt controller
// replays command records from a data file and checks the host side
`timescale 1ns/100ps
`default_nettype none

`include "irq_settings.svh"

module irq_ctrl_tb
    import irq_cfg_pkg::*, irq_disp_pkg::*;
();

    localparam int    CLK_PERIOD      = 40;
    localparam int    RESET_CYCLES    = 16;
    localparam int    VALID_TIMEOUT   = 64;
    localparam int    WATCHDOG_CYCLES = 80;
    localparam string STIM_FILE       = "test/irq_input.dat";

    // record kinds in the data file
    localparam int REC_CFG   = 0;
    localparam int REC_LINES = 1;
    localparam int REC_WAIT  = 2;
    localparam int REC_VEC   = 3;
    localparam int REC_QUIET = 4;

    // DUT ports
    logic       clk;
    logic       rst;
    irq_vec_t   irq_lines;
    logic       cfg_valid;
    cfg_op_e    cfg_op;
    irq_index_t cfg_line;
    logic       irq_ack;
    logic       irq_valid;
    irq_index_t irq_vector;

    // parsed records
    int          rec_kind [$];
    logic [31:0] rec_arg0 [$];
    logic [31:0] rec_arg1 [$];
    logic        records_loaded = 1'b0;

    // model of mask and mode, plus rises not yet presented
    irq_vec_t    shadow_mask;
    irq_vec_t    shadow_lines;
    irq_vec_t    shadow_raised;
    irq_mode_e   shadow_mode [`IRQ_COUNT];

    int          seed = 32'h53d67c8a;

    irq_ctrl_top u_irq_ctrl_top (
        .clk        (clk),
        .rst        (rst),
        .irq_lines  (irq_lines),
        .cfg_valid  (cfg_valid),
        .cfg_op     (cfg_op),
        .cfg_line   (cfg_line),
        .irq_ack    (irq_ack),
        .irq_valid  (irq_valid),
        .irq_vector (irq_vector)
    );

    `include "irq_ctrl_checks.svh"

    task automatic abort_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    function automatic int kind_code(input string kind);
        int code;
        code = -1;
        if (kind == "cfg") code = REC_CFG;
        if (kind == "lines") code = REC_LINES;
        if (kind == "wait") code = REC_WAIT;
        if (kind == "vec") code = REC_VEC;
        if (kind == "quiet") code = REC_QUIET;
        return code;
    endfunction

    // whole file into the record queues, # lines are skipped
    task automatic load_records();
        int               fd;
        int               got;
        string            kind;
        logic [31:0]      arg0;
        logic [31:0]      arg1;
        logic [8*128-1:0] rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file test/irq_input.dat");
        end else begin
            while (!$feof(fd)) begin
                got = $fscanf(fd, "%s", kind);
                if (got == 1 && kind == "#") begin
                    got = $fgets(rest, fd);
                end else if (got == 1) begin
                    got = $fscanf(fd, "%h %h", arg0, arg1);
                    // malformed argument list ends up as an unknown kind
                    rec_kind.push_back(got == 2 ? kind_code(kind) : -1);
                    rec_arg0.push_back(arg0);
                    rec_arg1.push_back(arg1);
                end
            end
            $fclose(fd);
        end
    endtask

    // one-cycle command strobe
    task automatic apply_config(input cfg_op_e op, input irq_index_t line);
        @(negedge clk);
        cfg_valid = 1'b1;
        cfg_op    = op;
        cfg_line  = line;
        @(negedge clk);
        cfg_valid = 1'b0;
        case (op)
            CFG_MASK:   shadow_mask[line] = 1'b1;
            CFG_UNMASK: shadow_mask[line] = 1'b0;
            CFG_EDGE:   shadow_mode[line] = MODE_EDGE;
            default:    shadow_mode[line] = MODE_LEVEL;
        endcase
    endtask

    task automatic drive_lines(input irq_vec_t value);
        @(negedge clk);
        shadow_raised = shadow_raised | (value & ~shadow_lines);
        shadow_lines  = value;
        irq_lines     = value;
    endtask

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // wait for valid, check the line, hold for a random time, then ack
    task automatic expect_vector(input irq_index_t expected);
        int waited;
        int delay;
        waited = 0;
        @(negedge clk);
        while (!irq_valid && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_valid(irq_valid, 1'b1, "irq_valid within 64 cycles");
        // an unmasked line only, and an edge line only after a fresh rise
        check_valid(shadow_mask[irq_vector], 1'b0, "mask of presented line");
        if (shadow_mode[irq_vector] == MODE_EDGE) begin
            check_valid(shadow_raised[irq_vector], 1'b1, "rise behind edge presentation");
            shadow_raised[irq_vector] = 1'b0;
        end
        check_vector(irq_vector, expected, "presented vector");
        delay = $random(seed) & 7;
        repeat (delay) begin
            @(negedge clk);
            check_valid(irq_valid, 1'b1, "irq_valid held before ack");
            check_vector(irq_vector, expected, "vector held before ack");
        end
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        // retire cycle has valid low
        check_valid(irq_valid, 1'b0, "irq_valid after ack");
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_valid(irq_valid, 1'b0, "irq_valid in quiet period");
        end
    endtask

    task automatic run_record(input int kind, input logic [31:0] arg0,
                              input logic [31:0] arg1);
        case (kind)
            REC_CFG:   apply_config(cfg_op_e'(arg0[1:0]), irq_index_t'(arg1));
            REC_LINES: drive_lines(irq_vec_t'(arg0));
            REC_WAIT:  wait_cycles(int'(arg0));
            REC_VEC:   expect_vector(irq_index_t'(arg0));
            REC_QUIET: expect_quiet(int'(arg0));
            default:   abort_run("unknown or malformed record in the stimulus file");
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // budget grows with the number of records
    initial begin : watchdog
        longint limit_ns;
        wait (records_loaded);
        limit_ns = longint'(rec_kind.size()) * WATCHDOG_CYCLES * CLK_PERIOD;
        #(limit_ns);
        abort_run("timeout: the record sequence did not finish in time");
    end

    initial begin
        rst       = 1'b1;
        irq_lines = '0;
        cfg_valid = 1'b0;
        cfg_op    = CFG_MASK;
        cfg_line  = '0;
        irq_ack   = 1'b0;
        // reset state of the controller
        shadow_mask   = '1;
        shadow_lines  = '0;
        shadow_raised = '0;
        for (int i = 0; i < `IRQ_COUNT; i++) begin
            shadow_mode[i] = MODE_EDGE;
        end
        load_records();
        records_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        foreach (rec_kind[i]) begin
            run_record(rec_kind[i], rec_arg0[i], rec_arg1[i]);
        end
        repeat (4) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/irq_ctrl_top.sv ====
// interrupt controller top level
// capture, priority encoder and dispatch in a chain
`timescale 1ns/100ps
`default_nettype none

`include "irq_settings.svh"

module irq_ctrl_top
    import irq_cfg_pkg::*, irq_disp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire irq_vec_t   irq_lines,
    input  wire logic       cfg_valid,
    input  wire cfg_op_e    cfg_op,
    input  wire irq_index_t cfg_line,
    input  wire logic       irq_ack,
    output logic            irq_valid,
    output irq_index_t      irq_vector
);

    // unmasked pending lines
    irq_vec_t   irq_request;

    // encoder result
    logic       req_valid;
    irq_index_t req_index;
    irq_vec_t   req_select;

    // clear pulse back from dispatch
    irq_vec_t   retire_mask;

    irq_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .irq_lines   (irq_lines),
        .cfg_valid   (cfg_valid),
        .cfg_op      (cfg_op),
        .cfg_line    (cfg_line),
        .retire_mask (retire_mask),
        .irq_request (irq_request)
    );

    priority_encoder #(
        .WIDTH             (`IRQ_COUNT),
        .LSB_HIGH_PRIORITY (`IRQ_LSB_FIRST)
    ) u_encoder (
        .unencoded (irq_request),
        .valid     (req_valid),
        .encoded   (req_index),
        .select    (req_select)
    );

    irq_dispatch u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_index   (req_index),
        .req_select  (req_select),
        .irq_ack     (irq_ack),
        .irq_valid   (irq_valid),
        .irq_vector  (irq_vector),
        .retire_mask (retire_mask)
    );

endmodule

`default_nettype wire

// ==== src/irq_dispatch.sv ====
// interrupt dispatch FSM
// latches the encoder winner, holds it for the host and retires it on ack
`timescale 1ns/100ps
`default_nettype none

module irq_dispatch
    import irq_disp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       req_valid,
    input  wire irq_index_t req_index,
    input  wire irq_vec_t   req_select,
    input  wire logic       irq_ack,
    output logic            irq_valid,
    output irq_index_t      irq_vector,
    output irq_vec_t        retire_mask
);

    disp_state_e state_q;
    disp_state_e state_d;

    // winner captured when leaving idle
    irq_index_t  vector_q;
    irq_vec_t    select_q;

    logic        load;

    // sample the encoder only while idle
    assign load = (state_q == DISP_IDLE) && req_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            DISP_IDLE: begin
                if (req_valid) begin
                    state_d = DISP_PRESENT;
                end
            end
            DISP_PRESENT: begin
                // slow ack just keeps us here
                if (irq_ack) begin
                    state_d = DISP_RETIRE;
                end
            end
            DISP_RETIRE: begin
                state_d = DISP_IDLE;
            end
            default: begin
                state_d = DISP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DISP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // vector stays frozen until the next idle pass
    always_ff @(posedge clk) begin
        if (load) begin
            vector_q <= req_index;
            select_q <= req_select;
        end
    end

    // host side
    assign irq_valid  = (state_q == DISP_PRESENT);
    assign irq_vector = vector_q;

    // single cycle clear towards capture
    assign retire_mask = (state_q == DISP_RETIRE) ? select_q : '0;

endmodule

`default_nettype wire

// ==== src/priority_encoder.sv ====
// parameterized tree priority encoder
// gives valid, the winning index and a one-hot select of that index
`timescale 1ns/100ps
`default_nettype none

module priority_encoder #(
    parameter int WIDTH = 4,
    // 1 when bit 0 has the highest priority
    parameter bit LSB_HIGH_PRIORITY = 0
) (
    input  wire logic [WIDTH-1:0]         unencoded,
    output logic                          valid,
    output logic [$clog2(WIDTH)-1:0]      encoded,
    output logic [WIDTH-1:0]              select
);

    // tree depth and padded width
    localparam int LEVELS = WIDTH > 2 ? $clog2(WIDTH) : 1;
    localparam int W = 2 ** LEVELS;

    // zero extend to a full power of two
    logic [W-1:0] padded;

    assign padded = W'(unencoded);

    // each level halves the node count and adds one index bit
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int NODES = W >> (l + 1);

        logic [NODES-1:0]       node_valid;
        logic [NODES*(l+1)-1:0] node_enc;

        for (genvar n = 0; n < NODES; n++) begin : g_node
            if (l == 0) begin : g_pair
                // leaf: one pair of input bits
                assign node_valid[n] = padded[2*n] | padded[2*n+1];
                if (LSB_HIGH_PRIORITY) begin : g_lsb
                    assign node_enc[n] = ~padded[2*n];
                end else begin : g_msb
                    assign node_enc[n] = padded[2*n+1];
                end
            end else begin : g_merge
                logic         lo_valid;
                logic         hi_valid;
                logic [l-1:0] lo_enc;
                logic [l-1:0] hi_enc;

                // two children from the level below
                assign lo_valid = g_level[l-1].node_valid[2*n];
                assign hi_valid = g_level[l-1].node_valid[2*n+1];
                assign lo_enc   = g_level[l-1].node_enc[2*n*l +: l];
                assign hi_enc   = g_level[l-1].node_enc[(2*n+1)*l +: l];

                assign node_valid[n] = lo_valid | hi_valid;

                // new msb says which child won
                if (LSB_HIGH_PRIORITY) begin : g_lsb
                    assign node_enc[n*(l+1) +: l+1] =
                        lo_valid ? {1'b0, lo_enc} : {1'b1, hi_enc};
                end else begin : g_msb
                    assign node_enc[n*(l+1) +: l+1] =
                        hi_valid ? {1'b1, hi_enc} : {1'b0, lo_enc};
                end
            end
        end
    end

    // root of the tree
    assign valid   = g_level[LEVELS-1].node_valid[0];
    assign encoded = g_level[LEVELS-1].node_enc;

    // one-hot of the winner, all zero with no request
    assign select = valid ? (WIDTH'(1) << encoded) : '0;

endmodule

`default_nettype wire

// ==== src/irq_capture.sv ====
// interrupt capture stage
// keeps mask and mode per line, detects rises and holds pending requests
`timescale 1ns/100ps
`default_nettype none

`include "irq_settings.svh"

module irq_capture
    import irq_cfg_pkg::*, irq_disp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire irq_vec_t   irq_lines,
    input  wire logic       cfg_valid,
    input  wire cfg_op_e    cfg_op,
    input  wire irq_index_t cfg_line,
    input  wire irq_vec_t   retire_mask,
    output irq_vec_t        irq_request
);

    // configuration state
    irq_vec_t  mask_q;
    irq_vec_t  mask_d;
    irq_mode_e mode_q [`IRQ_COUNT];
    irq_mode_e mode_d [`IRQ_COUNT];

    // line history and latched requests
    irq_vec_t  prev_q;
    irq_vec_t  pending_q;
    irq_vec_t  pending_d;

    // decoded command target and rising lines
    irq_vec_t  line_sel;
    irq_vec_t  rise;

    // one-hot line hit by the current command
    assign line_sel = cfg_valid ? (irq_vec_t'(1) << cfg_line) : '0;

    // low to high since the previous edge
    assign rise = irq_lines & ~prev_q;

    // command decode into per-line register updates
    always_comb begin
        mask_d = mask_q;
        mode_d = mode_q;
        for (int i = 0; i < `IRQ_COUNT; i++) begin
            if (line_sel[i]) begin
                case (cfg_op)
                    CFG_MASK:   mask_d[i] = 1'b1;
                    CFG_UNMASK: mask_d[i] = 1'b0;
                    CFG_EDGE:   mode_d[i] = MODE_EDGE;
                    CFG_LEVEL:  mode_d[i] = MODE_LEVEL;
                    default:    mask_d[i] = mask_q[i];
                endcase
            end
        end
    end

    // pending update depends on each line's mode
    always_comb begin
        for (int i = 0; i < `IRQ_COUNT; i++) begin
            if (mode_q[i] == MODE_EDGE) begin
                // a fresh rise wins over a retire in the same cycle
                pending_d[i] = rise[i] | (pending_q[i] & ~retire_mask[i]);
            end else begin
                // level lines ignore retire and track the pin
                pending_d[i] = irq_lines[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // everything masked, edge mode, nothing pending
            mask_q    <= '1;
            mode_q    <= '{default: MODE_EDGE};
            prev_q    <= '0;
            pending_q <= '0;
        end else begin
            mask_q    <= mask_d;
            mode_q    <= mode_d;
            prev_q    <= irq_lines;
            pending_q <= pending_d;
        end
    end

    // pending bits survive masking, only the request is hidden
    assign irq_request = pending_q & ~mask_q;

endmodule

`default_nettype wire

// ==== src/irq_disp_pkg.sv ====
// dispatch types for the interrupt controller
// line vector, line index and dispatch FSM states
`default_nettype none

`include "irq_settings.svh"

package irq_disp_pkg;

    // one bit per interrupt line
    typedef logic [`IRQ_COUNT-1:0] irq_vec_t;

    // binary line number as seen by the host
    typedef logic [$clog2(`IRQ_COUNT)-1:0] irq_index_t;

    // dispatch FSM
    typedef enum logic [1:0] {
        // waiting for an unmasked pending line
        DISP_IDLE    = 2'd0,
        // vector shown to the host until ack
        DISP_PRESENT = 2'd1,
        // one cycle of retire towards capture
        DISP_RETIRE  = 2'd2
    } disp_state_e;

endpackage

`default_nettype wire

// ==== src/irq_cfg_pkg.sv ====
// host configuration types for the interrupt controller
// command opcodes and per-line trigger mode
`default_nettype none

`include "irq_settings.svh"

package irq_cfg_pkg;

    // one-cycle command carried with cfg_valid
    typedef enum logic [1:0] {
        CFG_MASK   = 2'd0,
        CFG_UNMASK = 2'd1,
        CFG_EDGE   = 2'd2,
        CFG_LEVEL  = 2'd3
    } cfg_op_e;

    // trigger mode of one line
    // edge lines latch a rise until retired, level lines follow the pin
    typedef enum logic {
        MODE_LEVEL = 1'b0,
        MODE_EDGE  = 1'b1
    } irq_mode_e;

endpackage

`default_nettype wire

// ==== src/irq_settings.svh ====
// interrupt controller build settings
// line count and priority direction shared by packages and RTL

`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// number of raw interrupt lines
// also sets the priority encoder width
`define IRQ_COUNT 16

// priority direction of the encoder
// 1 means line 0 wins over every other line
// 0 means the highest index wins
`define IRQ_LSB_FIRST 1

`endif
